// File: hw/refill_settings.svh
/*
 * Width and sizing constants for the cache refill read arbiter.
 * Included by the package and by every RTL module that sizes a port or a field.
 */
`ifndef REFILL_SETTINGS_SVH
`define REFILL_SETTINGS_SVH

// One memory data beat
`define REFILL_MEM_DATA_W     64
// Instruction-cache line, a whole number of beats
`define REFILL_ICACHE_LINE_W  128
`define REFILL_BEATS_PER_LINE 2

`define REFILL_ID_W           4
`define REFILL_ADDR_W         32

// log2 of the bytes in one uncached word
`define REFILL_NC_SIZE        3

// Instruction cache, data-cache miss path, uncached-read path
`define REFILL_NUM_REQ        3

`endif

// File: hw/refill_pkg.sv
/*
 * Request, response and refill types shared by the refill arbiter blocks.
 * Modules take these with a wildcard import in their header.
 */
`include "refill_settings.svh"

package refill_pkg;

  typedef logic [`REFILL_ID_W-1:0]   mem_id_t;
  typedef logic [`REFILL_ADDR_W-1:0] mem_addr_t;

  // Slot of a beat inside an instruction-cache line
  typedef logic [$clog2(`REFILL_BEATS_PER_LINE)-1:0] beat_slot_t;

  // Read request on the memory channel
  typedef struct packed {
    mem_addr_t  addr;
    logic [7:0] len;
    logic [2:0] size;
    mem_id_t    id;
    logic       cacheable;
  } mem_read_req_t;

  // One read response beat
  typedef struct packed {
    logic [`REFILL_MEM_DATA_W-1:0] data;
    mem_id_t                       id;
    logic                          last;
    logic                          error;
  } mem_read_resp_t;

  // Miss as issued by the instruction cache
  typedef struct packed {
    mem_addr_t paddr;
    logic      nc;
    mem_id_t   tid;
  } icache_miss_req_t;

  // Full line handed back to the instruction cache
  typedef struct packed {
    logic [`REFILL_ICACHE_LINE_W-1:0] data;
    mem_id_t                          tid;
  } icache_refill_t;

  // Requester index, also the arbiter and demux port number
  typedef enum logic [1:0] {
    SEL_ICACHE      = 2'd0,
    SEL_DCACHE_MISS = 2'd1,
    SEL_UC_READ     = 2'd2
  } req_sel_t;

endpackage

// File: hw/icache_miss_adapter.sv
/*
 * One-entry slot between the instruction-cache miss port and the read arbiter.
 * Converts the miss into a memory read request and holds it until memory takes it.
 */
`timescale 1ns/1ns
`include "refill_settings.svh"

module icache_miss_adapter
  import refill_pkg::*;
(
  input  logic             clk_i,
  input  logic             arst_n_i,

  input  logic             miss_valid_i,
  input  icache_miss_req_t miss_i,
  output logic             miss_ready_o,

  output logic             req_valid_o,
  output mem_read_req_t    req_o,
  input  logic             req_ready_i
);

  localparam logic [7:0] LINE_LEN  = 8'(`REFILL_BEATS_PER_LINE - 1);
  localparam logic [2:0] BEAT_SIZE = 3'($clog2(`REFILL_MEM_DATA_W / 8));
  localparam logic [2:0] NC_SIZE   = 3'(`REFILL_NC_SIZE);

  logic          slot_full_q;
  mem_read_req_t slot_q;
  mem_read_req_t req_built;
  logic          miss_take;
  logic          req_take;

  // Cacheable misses fetch a whole line, nc misses a single word
  always_comb begin
    req_built.addr      = miss_i.paddr;
    req_built.len       = miss_i.nc ? 8'd0 : LINE_LEN;
    req_built.size      = miss_i.nc ? NC_SIZE : BEAT_SIZE;
    req_built.id        = miss_i.tid;
    req_built.cacheable = ~miss_i.nc;
  end

  assign miss_ready_o = ~slot_full_q;
  assign miss_take    = miss_valid_i & miss_ready_o;
  assign req_take     = req_valid_o & req_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      slot_full_q <= 1'b0;
    end else if (miss_take) begin
      slot_full_q <= 1'b1;
    end else if (req_take) begin
      slot_full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (miss_take) begin
      slot_q <= req_built;
    end
  end

  assign req_valid_o = slot_full_q;
  assign req_o       = slot_q;

  // A held request keeps its contents until the arbiter drains it
  a_slot_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    slot_full_q && !req_take |=> slot_full_q && $stable(slot_q));

endmodule

// File: hw/read_req_arbiter.sv
/*
 * Round-robin arbiter for the three read requesters onto the memory channel.
 * The chosen request is registered in IDLE and held in GRANT until memory accepts.
 */
`timescale 1ns/1ns
`include "refill_settings.svh"

module read_req_arbiter
  import refill_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                arst_n_i,

  input  logic          [`REFILL_NUM_REQ-1:0] req_valid_i,
  input  mem_read_req_t [`REFILL_NUM_REQ-1:0] req_i,
  output logic          [`REFILL_NUM_REQ-1:0] req_ready_o,

  output logic                                mem_req_valid_o,
  output mem_read_req_t                       mem_req_o,
  input  logic                                mem_req_ready_i
);

  typedef enum logic {
    IDLE,
    GRANT
  } state_e;

  state_e   state_q;
  req_sel_t sel_q;
  req_sel_t prio_q;
  req_sel_t pick;
  logic     pick_valid;

  function automatic req_sel_t rr_next(req_sel_t s);
    return (s == SEL_UC_READ) ? SEL_ICACHE : req_sel_t'(s + 2'd1);
  endfunction

  // First valid input at or after the priority pointer
  always_comb begin
    req_sel_t idx;
    pick_valid = 1'b0;
    pick       = prio_q;
    idx        = prio_q;
    for (int k = 0; k < `REFILL_NUM_REQ; k++) begin
      if (!pick_valid && req_valid_i[idx]) begin
        pick_valid = 1'b1;
        pick       = idx;
      end
      idx = rr_next(idx);
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      sel_q   <= SEL_ICACHE;
      prio_q  <= SEL_ICACHE;
    end else begin
      case (state_q)
        IDLE: begin
          if (pick_valid) begin
            state_q <= GRANT;
            sel_q   <= pick;
          end
        end
        GRANT: begin
          if (mem_req_ready_i) begin
            state_q <= IDLE;
            prio_q  <= rr_next(sel_q);
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Requesters keep their payload stable, so the grant can mux straight from the inputs
  assign mem_req_valid_o = (state_q == GRANT);
  assign mem_req_o       = req_i[sel_q];

  always_comb begin
    req_ready_o = '0;
    if ((state_q == GRANT) && mem_req_ready_i) begin
      req_ready_o[sel_q] = 1'b1;
    end
  end

  a_mem_req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o));

  a_one_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(req_ready_o));

endmodule

// File: hw/refill_beat_counter.sv
/*
 * Beat counter for instruction-cache refills.
 * Gives the line slot of the current beat and wraps to zero after the last one.
 */
`timescale 1ns/1ns
`include "refill_settings.svh"

module refill_beat_counter
  import refill_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,

  input  logic       beat_i,
  input  logic       last_i,
  output beat_slot_t slot_o
);

  localparam beat_slot_t LAST_SLOT = beat_slot_t'(`REFILL_BEATS_PER_LINE - 1);

  beat_slot_t count_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= '0;
    end else if (beat_i) begin
      if (last_i) begin
        count_q <= '0;
      end else begin
        count_q <= beat_slot_t'(count_q + 1'b1);
      end
    end
  end

  assign slot_o = count_q;

  // Memory must close the burst on the final slot at the latest
  a_no_overrun: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    beat_i && !last_i |-> count_q != LAST_SLOT);

endmodule

// File: hw/icache_refill_upsize.sv
/*
 * Assembles narrow memory beats into one instruction-cache line.
 * The finished line and its ID are presented for a single cycle after the last beat.
 */
`timescale 1ns/1ns
`include "refill_settings.svh"

module icache_refill_upsize
  import refill_pkg::*;
(
  input  logic           clk_i,
  input  logic           arst_n_i,

  input  logic           beat_valid_i,
  input  mem_read_resp_t beat_i,
  input  beat_slot_t     slot_i,

  output logic           refill_valid_o,
  output icache_refill_t refill_o
);

  typedef logic [`REFILL_BEATS_PER_LINE-1:0][`REFILL_MEM_DATA_W-1:0] line_t;

  line_t          line_q;
  line_t          line_next;
  logic           refill_valid_q;
  icache_refill_t refill_q;

  // Current line with the incoming beat merged into its slot
  always_comb begin
    line_next         = line_q;
    line_next[slot_i] = beat_i.data;
  end

  always_ff @(posedge clk_i) begin
    if (beat_valid_i) begin
      line_q <= line_next;
    end
    if (beat_valid_i && beat_i.last) begin
      refill_q.data <= line_next;
      refill_q.tid  <= beat_i.id;
    end
  end

  // Single-cycle pulse, the instruction cache has no back-pressure
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      refill_valid_q <= 1'b0;
    end else begin
      refill_valid_q <= beat_valid_i & beat_i.last;
    end
  end

  assign refill_valid_o = refill_valid_q;
  assign refill_o       = refill_q;

endmodule

// File: hw/read_resp_demux.sv
/*
 * Routes each memory response beat to its requester by transaction ID.
 * Purely combinational, the beat payload itself fans out at the top level.
 */
`timescale 1ns/1ns
`include "refill_settings.svh"

module read_resp_demux
  import refill_pkg::*;
(
  input  logic                       mem_resp_valid_i,
  input  mem_read_resp_t             mem_resp_i,
  output logic                       mem_resp_ready_o,

  input  mem_id_t                    icache_id_i,
  input  mem_id_t                    uc_read_id_i,

  output logic [`REFILL_NUM_REQ-1:0] out_valid_o,
  input  logic [`REFILL_NUM_REQ-1:0] out_ready_i
);

  req_sel_t sel;

  // Instruction-cache ID wins over the uncached ID if both match
  always_comb begin
    if (mem_resp_i.id == icache_id_i) begin
      sel = SEL_ICACHE;
    end else if (mem_resp_i.id == uc_read_id_i) begin
      sel = SEL_UC_READ;
    end else begin
      sel = SEL_DCACHE_MISS;
    end
  end

  always_comb begin
    out_valid_o      = '0;
    out_valid_o[sel] = mem_resp_valid_i;
  end

  // Back-pressure of the selected port goes straight to memory
  assign mem_resp_ready_o = out_ready_i[sel];

endmodule

// File: hw/cache_refill_arbiter.sv
/*
 * Read side of the cache subsystem memory arbiter.
 * Shares one memory read channel between the I-cache miss path, the D-cache miss
 * path and the D-cache uncached-read path, and routes responses back by ID.
 */
`timescale 1ns/1ns
`include "refill_settings.svh"

module cache_refill_arbiter
  import refill_pkg::*;
(
  input  logic             clk_i,
  input  logic             arst_n_i,

  // Instruction cache
  input  logic             icache_miss_valid_i,
  input  icache_miss_req_t icache_miss_i,
  output logic             icache_miss_ready_o,
  output logic             icache_refill_valid_o,
  output icache_refill_t   icache_refill_o,
  input  mem_id_t          icache_id_i,

  // Data-cache miss path
  input  logic             dcache_miss_valid_i,
  input  mem_read_req_t    dcache_miss_i,
  output logic             dcache_miss_ready_o,
  output logic             dcache_miss_resp_valid_o,
  output mem_read_resp_t   dcache_miss_resp_o,
  input  logic             dcache_miss_resp_ready_i,

  // Data-cache uncached reads
  input  logic             uc_read_valid_i,
  input  mem_read_req_t    uc_read_i,
  output logic             uc_read_ready_o,
  output logic             uc_read_resp_valid_o,
  output mem_read_resp_t   uc_read_resp_o,
  input  logic             uc_read_resp_ready_i,
  input  mem_id_t          uc_read_id_i,

  // Memory read channel
  output logic             mem_req_valid_o,
  output mem_read_req_t    mem_req_o,
  input  logic             mem_req_ready_i,
  input  logic             mem_resp_valid_i,
  input  mem_read_resp_t   mem_resp_i,
  output logic             mem_resp_ready_o
);

  logic          [`REFILL_NUM_REQ-1:0] req_valid;
  mem_read_req_t [`REFILL_NUM_REQ-1:0] req;
  logic          [`REFILL_NUM_REQ-1:0] req_ready;
  logic          [`REFILL_NUM_REQ-1:0] resp_valid;
  logic          [`REFILL_NUM_REQ-1:0] resp_ready;
  beat_slot_t                          beat_slot;

  icache_miss_adapter icache_miss_adapter_inst (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .miss_valid_i (icache_miss_valid_i),
    .miss_i       (icache_miss_i),
    .miss_ready_o (icache_miss_ready_o),
    .req_valid_o  (req_valid[SEL_ICACHE]),
    .req_o        (req[SEL_ICACHE]),
    .req_ready_i  (req_ready[SEL_ICACHE])
  );

  assign req_valid[SEL_DCACHE_MISS] = dcache_miss_valid_i;
  assign req[SEL_DCACHE_MISS]       = dcache_miss_i;
  assign dcache_miss_ready_o        = req_ready[SEL_DCACHE_MISS];
  assign req_valid[SEL_UC_READ]     = uc_read_valid_i;
  assign req[SEL_UC_READ]           = uc_read_i;
  assign uc_read_ready_o            = req_ready[SEL_UC_READ];

  read_req_arbiter read_req_arbiter_inst (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .req_valid_i     (req_valid),
    .req_i           (req),
    .req_ready_o     (req_ready),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_o       (mem_req_o),
    .mem_req_ready_i (mem_req_ready_i)
  );

  // Upsizer never stalls
  assign resp_ready[SEL_ICACHE]      = 1'b1;
  assign resp_ready[SEL_DCACHE_MISS] = dcache_miss_resp_ready_i;
  assign resp_ready[SEL_UC_READ]     = uc_read_resp_ready_i;

  read_resp_demux read_resp_demux_inst (
    .mem_resp_valid_i (mem_resp_valid_i),
    .mem_resp_i       (mem_resp_i),
    .mem_resp_ready_o (mem_resp_ready_o),
    .icache_id_i      (icache_id_i),
    .uc_read_id_i     (uc_read_id_i),
    .out_valid_o      (resp_valid),
    .out_ready_i      (resp_ready)
  );

  assign dcache_miss_resp_valid_o = resp_valid[SEL_DCACHE_MISS];
  assign dcache_miss_resp_o       = mem_resp_i;
  assign uc_read_resp_valid_o     = resp_valid[SEL_UC_READ];
  assign uc_read_resp_o           = mem_resp_i;

  refill_beat_counter refill_beat_counter_inst (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .beat_i   (resp_valid[SEL_ICACHE]),
    .last_i   (mem_resp_i.last),
    .slot_o   (beat_slot)
  );

  icache_refill_upsize icache_refill_upsize_inst (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .beat_valid_i   (resp_valid[SEL_ICACHE]),
    .beat_i         (mem_resp_i),
    .slot_i         (beat_slot),
    .refill_valid_o (icache_refill_valid_o),
    .refill_o       (icache_refill_o)
  );

endmodule

// File: tests/tb_refill_mem_model.sv
/*
 * Behavioral memory for the refill arbiter testbench.
 * Accepts every read request, queues it and returns len+1 beats with random stalls.
 */
`timescale 1ns/1ns

module tb_refill_mem_model
  import refill_pkg::*;
(
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           req_valid_i,
  input  mem_read_req_t  req_i,
  output logic           req_ready_o,
  output logic           resp_valid_o,
  output mem_read_resp_t resp_o,
  input  logic           resp_ready_i
);

  mem_read_req_t pending[$];
  int            beat_idx;
  integer        seed = 95115;
  logic          busy;

  // Beat k carries the address plus k*8 in both halves
  function automatic mem_read_resp_t make_beat(mem_read_req_t r, int k);
    mem_read_resp_t b;
    logic [31:0]    word;
    word    = r.addr + 32'(k * 8);
    b.data  = {word, word};
    b.id    = r.id;
    b.last  = (k == int'(r.len));
    b.error = 1'b0;
    return b;
  endfunction

  assign req_ready_o = 1'b1;

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_valid_o <= 1'b0;
      resp_o       <= '0;
      beat_idx = 0;
      pending.delete();
    end else begin
      busy = resp_valid_o;
      if (resp_valid_o && resp_ready_i) begin
        busy = 1'b0;
        if (resp_o.last) begin
          void'(pending.pop_front());
          beat_idx = 0;
        end else begin
          beat_idx++;
        end
      end
      if (req_valid_i && req_ready_o) begin
        pending.push_back(req_i);
      end
      // A raised beat holds until taken
      if (!busy) begin
        if (pending.size() > 0 && ($unsigned($random(seed)) % 3 != 0)) begin
          resp_valid_o <= 1'b1;
          resp_o       <= make_beat(pending[0], beat_idx);
        end else begin
          resp_valid_o <= 1'b0;
        end
      end
    end
  end

endmodule

// File: tests/tb_cache_refill_arbiter.sv
/*
 * Testbench for the cache refill read arbiter.
 * Applies a stimulus table one entry at a time against a behavioral memory and
 * checks the memory requests, the routed beats and the assembled refills.
 */
`timescale 1ns/1ns
`include "refill_settings.svh"

module tb_cache_refill_arbiter
  import refill_pkg::*;
();

  localparam int NUM_TESTS = 7;
  localparam logic [3:0] IC_ID = 4'h1;
  localparam logic [3:0] UC_ID = 4'h2;

  // req 3 means all three requesters at once
  typedef struct packed {
    logic [1:0]  req;
    logic [31:0] addr;
    logic        nc;
    logic [3:0]  id;
    logic        hold;
  } stim_t;

  logic clk_i;
  logic arst_n_i;
  logic icache_miss_valid_i;
  icache_miss_req_t icache_miss_i;
  logic icache_miss_ready_o;
  logic icache_refill_valid_o;
  icache_refill_t icache_refill_o;
  logic dcache_miss_valid_i;
  mem_read_req_t dcache_miss_i;
  logic dcache_miss_ready_o;
  logic dcache_miss_resp_valid_o;
  mem_read_resp_t dcache_miss_resp_o;
  logic dcache_miss_resp_ready_i;
  logic uc_read_valid_i;
  mem_read_req_t uc_read_i;
  logic uc_read_ready_o;
  logic uc_read_resp_valid_o;
  mem_read_resp_t uc_read_resp_o;
  logic uc_read_resp_ready_i;
  logic mem_req_valid_o;
  mem_read_req_t mem_req_o;
  logic mem_req_ready_i;
  logic mem_resp_valid_i;
  mem_read_resp_t mem_resp_i;
  logic mem_resp_ready_o;

  stim_t stim [NUM_TESTS];
  mem_read_req_t memq[$];
  mem_read_resp_t dq[$];
  mem_read_resp_t uq[$];
  icache_refill_t rq[$];
  int errors = 0;
  int passed = 0;
  int stall_cycles = 0;
  logic stall_seen;
  mem_read_resp_t stall_beat;

  cache_refill_arbiter cache_refill_arbiter_inst (.*, .icache_id_i(IC_ID), .uc_read_id_i(UC_ID));

  tb_refill_mem_model mem_model_inst (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .req_valid_i(mem_req_valid_o), .req_i(mem_req_o), .req_ready_o(mem_req_ready_i),
    .resp_valid_o(mem_resp_valid_i), .resp_o(mem_resp_i), .resp_ready_i(mem_resp_ready_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic check(input string name, input logic [135:0] got, input logic [135:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  function automatic logic [63:0] beat_data(logic [31:0] addr, int k);
    logic [31:0] w;
    w = addr + 32'(k * 8);
    return {w, w};
  endfunction

  // Request a requester should put on memory
  function automatic mem_read_req_t req_for(int sel, logic [31:0] addr, logic nc, logic [3:0] id);
    mem_read_req_t r;
    r.addr      = addr;
    r.len       = (sel == 2 || nc) ? 8'd0 : 8'(`REFILL_BEATS_PER_LINE - 1);
    r.size      = (sel == 0 && nc) ? 3'(`REFILL_NC_SIZE) : 3'd3;
    r.id        = id;
    r.cacheable = (sel != 2) && !nc;
    return r;
  endfunction

  task automatic issue(input int sel, input logic [31:0] addr, input logic nc,
                       input logic [3:0] id);
    if (sel == 0) begin
      icache_miss_valid_i = 1'b1;
      icache_miss_i = '{paddr: addr, nc: nc, tid: id};
      @(posedge clk_i);
      while (!icache_miss_ready_o) @(posedge clk_i);
      #1 icache_miss_valid_i = 1'b0;
      // Slot now holds the miss
      check("icache_miss_ready_o", 136'(icache_miss_ready_o), 136'(0));
    end else if (sel == 1) begin
      dcache_miss_valid_i = 1'b1;
      dcache_miss_i = req_for(1, addr, nc, id);
      @(posedge clk_i);
      while (!dcache_miss_ready_o) @(posedge clk_i);
      #1 dcache_miss_valid_i = 1'b0;
      check("dcache_miss_ready_o", 136'(dcache_miss_ready_o), 136'(0));
    end else begin
      uc_read_valid_i = 1'b1;
      uc_read_i = req_for(2, addr, nc, id);
      @(posedge clk_i);
      while (!uc_read_ready_o) @(posedge clk_i);
      #1 uc_read_valid_i = 1'b0;
      check("uc_read_ready_o", 136'(uc_read_ready_o), 136'(0));
    end
  endtask

  // Response monitors and the stall check
  always @(posedge clk_i) begin
    if (arst_n_i) begin
      if (mem_req_valid_o && mem_req_ready_i) memq.push_back(mem_req_o);
      if (dcache_miss_resp_valid_o && dcache_miss_resp_ready_i) dq.push_back(dcache_miss_resp_o);
      if (uc_read_resp_valid_o && uc_read_resp_ready_i) uq.push_back(uc_read_resp_o);
      if (icache_refill_valid_o) rq.push_back(icache_refill_o);
      if (stall_seen) begin
        check("dcache_miss_resp_valid_o", 136'(dcache_miss_resp_valid_o), 136'(1));
        check("dcache_miss_resp_o", 136'(dcache_miss_resp_o), 136'(stall_beat));
      end
      stall_seen = dcache_miss_resp_valid_o && !dcache_miss_resp_ready_i;
      if (stall_seen) begin
        check("mem_resp_ready_o", 136'(mem_resp_ready_o), 136'(0));
        stall_beat = dcache_miss_resp_o;
        stall_cycles++;
      end
    end else begin
      stall_seen = 1'b0;
    end
  end

  initial begin
    repeat (NUM_TESTS * 200) @(posedge clk_i);
    $display("Timeout: the tests did not complete in %0d cycles", NUM_TESTS * 200);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    int prio;
    int err_before;
    int sel;
    logic [31:0] a;
    logic [3:0] id;
    stim[0] = '{req: 2'd0, addr: 32'h1000, nc: 1'b0, id: IC_ID, hold: 1'b0};
    stim[1] = '{req: 2'd0, addr: 32'h2008, nc: 1'b1, id: IC_ID, hold: 1'b0};
    stim[2] = '{req: 2'd1, addr: 32'h3000, nc: 1'b0, id: 4'h5, hold: 1'b0};
    stim[3] = '{req: 2'd2, addr: 32'h4010, nc: 1'b0, id: UC_ID, hold: 1'b0};
    stim[4] = '{req: 2'd3, addr: 32'h5000, nc: 1'b0, id: 4'h6, hold: 1'b0};
    stim[5] = '{req: 2'd1, addr: 32'h6000, nc: 1'b0, id: 4'h7, hold: 1'b1};
    stim[6] = '{req: 2'd3, addr: 32'h7000, nc: 1'b0, id: 4'h9, hold: 1'b0};
    prio = 0;
    arst_n_i = 1'b0;
    icache_miss_valid_i = 1'b0;
    icache_miss_i = '0;
    dcache_miss_valid_i = 1'b0;
    dcache_miss_i = '0;
    dcache_miss_resp_ready_i = 1'b1;
    uc_read_valid_i = 1'b0;
    uc_read_i = '0;
    uc_read_resp_ready_i = 1'b1;
    repeat (3) @(posedge clk_i);
    #1 arst_n_i = 1'b1;
    check("mem_req_valid_o", 136'(mem_req_valid_o), 136'(0));
    check("icache_refill_valid_o", 136'(icache_refill_valid_o), 136'(0));
    check("dcache_miss_resp_valid_o", 136'(dcache_miss_resp_valid_o), 136'(0));
    check("uc_read_resp_valid_o", 136'(uc_read_resp_valid_o), 136'(0));
    check("dcache_miss_ready_o", 136'(dcache_miss_ready_o), 136'(0));
    check("uc_read_ready_o", 136'(uc_read_ready_o), 136'(0));
    @(posedge clk_i);
    #1;
    for (int t = 0; t < NUM_TESTS; t++) begin
      err_before = errors;
      memq.delete();
      dq.delete();
      uq.delete();
      rq.delete();
      stall_cycles = 0;
      if (stim[t].req == 2'd3) begin
        // I-cache first so all three meet at the arbiter in the same cycle
        issue(0, stim[t].addr, 1'b0, IC_ID);
        fork
          issue(1, stim[t].addr + 32'h100, 1'b0, stim[t].id);
          issue(2, stim[t].addr + 32'h200, 1'b0, UC_ID);
        join
      end else if (stim[t].hold) begin
        fork
          issue(stim[t].req, stim[t].addr, stim[t].nc, stim[t].id);
          begin
            dcache_miss_resp_ready_i = 1'b0;
            repeat (12) @(posedge clk_i);
            #1 dcache_miss_resp_ready_i = 1'b1;
          end
        join
      end else begin
        issue(stim[t].req, stim[t].addr, stim[t].nc, stim[t].id);
      end
      while (!(rq.size() >= int'(stim[t].req inside {0, 3}) &&
               dq.size() >= 2 * int'(stim[t].req inside {1, 3}) &&
               uq.size() >= int'(stim[t].req inside {2, 3}))) @(posedge clk_i);
      repeat (3) @(posedge clk_i);
      #1;
      check("mem request count", 136'(memq.size()), 136'(stim[t].req == 3 ? 3 : 1));
      for (int j = 0; j < memq.size(); j++) begin
        sel = (stim[t].req == 3) ? (prio + j) % 3 : int'(stim[t].req);
        a   = (stim[t].req == 3) ? stim[t].addr + 32'(sel * 'h100) : stim[t].addr;
        id  = (sel == 0) ? IC_ID : (sel == 2) ? UC_ID : stim[t].id;
        check("mem_req_o", 136'(memq[j]), 136'(req_for(sel, a, stim[t].nc && sel == 0, id)));
        if (sel == 0 && rq.size() == 1) begin
          check("icache_refill_o.tid", 136'(rq[0].tid), 136'(IC_ID));
          if (stim[t].nc) begin
            check("icache_refill_o.data", 136'(rq[0].data[63:0]), 136'(beat_data(a, 0)));
          end else begin
            check("icache_refill_o.data", 136'(rq[0].data),
                  136'({beat_data(a, 1), beat_data(a, 0)}));
          end
        end
        if (sel == 1 && dq.size() == 2) begin
          for (int k = 0; k < 2; k++) begin
            check("dcache_miss_resp_o", 136'(dq[k]),
                  136'({beat_data(a, k), id, k == 1, 1'b0}));
          end
        end
        if (sel == 2 && uq.size() == 1) begin
          check("uc_read_resp_o", 136'(uq[0]), 136'({beat_data(a, 0), UC_ID, 1'b1, 1'b0}));
        end
      end
      check("icache refill count", 136'(rq.size()), 136'(stim[t].req inside {0, 3}));
      check("dcache beat count", 136'(dq.size()), 136'(2 * (stim[t].req inside {1, 3})));
      check("uncached beat count", 136'(uq.size()), 136'(stim[t].req inside {2, 3}));
      if (stim[t].hold) begin
        check("dcache stalled beat seen", 136'(stall_cycles > 0), 136'(1));
      end
      if (stim[t].req != 3) prio = (int'(stim[t].req) + 1) % 3;
      if (errors == err_before) begin
        passed++;
        $display("Test %0d passed", t);
      end else begin
        $display("Test %0d failed", t);
      end
    end
    $display("%0d tests, %0d passed, %0d errors", NUM_TESTS, passed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: cache_refill_arbiter.f
+incdir+hw
hw/refill_pkg.sv
hw/icache_miss_adapter.sv
hw/read_req_arbiter.sv
hw/refill_beat_counter.sv
hw/icache_refill_upsize.sv
hw/read_resp_demux.sv
hw/cache_refill_arbiter.sv
tests/tb_refill_mem_model.sv
tests/tb_cache_refill_arbiter.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the refill arbiter testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f cache_refill_arbiter.f \
  --top-module tb_cache_refill_arbiter \
  -Mdir build

./build/Vtb_cache_refill_arbiter | tee sim.log

if grep -q "Finished with errors" sim.log; then
  echo "Simulation failed"
  exit 1
fi

if ! grep -q "Finished with no errors" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

echo "Simulation passed"
